/* all.f */
+incdir+logic
logic/disp_pkg.sv
logic/disp_timing_if.sv
logic/syncgen.sv
logic/disp_ctrl.sv
logic/disp_fifo.sv
logic/disp_out.sv
logic/disp_ip.sv
verification/tb_disp_ip.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then look for the failure line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_disp_ip \
    -f all.f -o tb_disp_ip > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_disp_ip > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

/* verification/tb_disp_ip.sv */
`timescale 1ns/1ns
`include "disp_macros.svh"

module tb_disp_ip;

    localparam int H_PER       = 2 * `DISP_H_TOTAL;    // clks per line
    localparam int V_PER       = H_PER * `DISP_V_TOTAL; // clks per frame
    localparam int TIMEOUT     = 12 * V_PER;
    localparam int FRAME_BURST = `DISP_H_ACTIVE * `DISP_V_ACTIVE / `DISP_BURST;

    logic                         clk               = 1'b0;
    logic                         rst               = 1'b1;
    logic                         avm_waitrequest   = 1'b1;
    logic [15:0]                  avm_readdata      = '0;
    logic                         avm_readdatavalid = 1'b0;
    logic [25:0]                  disp_addr         = 26'h00a_5c60;
    logic                         disp_on           = 1'b1;
    logic                         clr_vblank        = 1'b0;
    logic [25:0]                  avm_address;
    logic                         avm_read;
    logic [$clog2(`DISP_BURST):0] avm_burstcount;
    logic [3:0]                   vga_r;
    logic [3:0]                   vga_g;
    logic [3:0]                   vga_b;
    logic                         vga_hs;
    logic                         vga_vs;
    logic                         vblank;

    logic [31:0] lfsr       = 32'hdcb5_e77b;
    int          value_errs = 0;
    int          other_errs = 0;
    int          ncyc       = 0;
    int          c          = 0;    // clks since the last VS fall
    int          hs_t       = 0;
    int          vs_falls   = 0;
    int          waited     = 0;
    bit          synced     = 1'b0;
    bit          hs_seen    = 1'b0;
    logic        hs_q       = 1'b1;
    logic        vs_q       = 1'b1;
    logic        read_q     = 1'b0;
    logic [25:0] addr_q     = '0;
    logic        exp_vb     = 1'b0;
    int          beats_left = 0;    // memory model, beats still owed
    int          burst_n    = 0;
    logic [25:0] word_idx   = '0;

    disp_ip i_disp_ip (
        .clk               (clk),
        .rst               (rst),
        .avm_waitrequest   (avm_waitrequest),
        .avm_readdata      (avm_readdata),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_address       (avm_address),
        .avm_read          (avm_read),
        .avm_burstcount    (avm_burstcount),
        .vga_r             (vga_r),
        .vga_g             (vga_g),
        .vga_b             (vga_b),
        .vga_hs            (vga_hs),
        .vga_vs            (vga_vs),
        .disp_addr         (disp_addr),
        .disp_on           (disp_on),
        .clr_vblank        (clr_vblank),
        .vblank            (vblank)
    );

    always #4 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic rand_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    // memory holds the low 12 bits of each word index
    function automatic logic [11:0] pixel_word(input int k);
        logic [25:0] idx;
        idx = (disp_addr >> 1) + 26'(k);
        return idx[11:0];
    endfunction

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got == exp) else begin
            value_errs++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond) else begin
            other_errs++;
            $display("ERROR: %s at %0t", what, $time);
        end
    endtask

    always @(negedge clk) begin : bench
        int          x;
        int          y;
        logic [11:0] exp_rgb;
        logic        gap;

        ncyc++;
        if (ncyc == 2) begin
            expect_value("avm_read", avm_read, 0);   // still in reset here
            expect_value("vga_hs", vga_hs, 1);
            expect_value("vga_vs", vga_vs, 1);
            expect_value("rgb", {vga_r, vga_g, vga_b}, 0);
            expect_value("vblank", vblank, 0);
            rst = 1'b0;
        end else if (ncyc > 2) begin
            ////////////////////
            // sync pulse widths and periods
            c++;
            hs_t++;
            if (hs_q && !vga_hs) begin
                if (hs_seen) expect_value("hs period", hs_t, H_PER);
                hs_t    = 0;
                hs_seen = 1'b1;
            end
            if (!hs_q && vga_hs && hs_seen) begin
                expect_value("hs low width", hs_t, 2 * `DISP_H_SYNC_WIDTH);
            end
            if (vs_q && !vga_vs) begin
                if (synced) expect_value("vs period", c, V_PER);
                c      = 0;
                synced = 1'b1;
                vs_falls++;
            end
            if (!vs_q && vga_vs && synced) begin
                expect_value("vs low width", c, H_PER * `DISP_V_SYNC_WIDTH);
            end
            hs_q = vga_hs;
            vs_q = vga_vs;

            // raster position rebuilt from the VS fall, pixel held 2 clks
            if (synced) begin
                x       = (c % H_PER) / 2;
                y       = (`DISP_V_SYNC_START + c / H_PER) % `DISP_V_TOTAL;
                exp_rgb = 12'h000;
                if (disp_on && x < `DISP_H_ACTIVE && y < `DISP_V_ACTIVE) begin
                    exp_rgb = pixel_word(y * `DISP_H_ACTIVE + x);
                end
                expect_value("rgb", {vga_r, vga_g, vga_b}, exp_rgb);
            end

            if (clr_vblank) begin
                exp_vb = 1'b0;                  // clear wins
            end else if (synced && c == 1) begin
                exp_vb = 1'b1;
            end
            expect_value("vblank", vblank, exp_vb);

            ////////////////////
            // avalon side
            if (read_q && avm_waitrequest) begin
                require(avm_read, "avm_read dropped while waitrequest was high");
                expect_value("avm_address", avm_address, addr_q);
            end
            if (avm_read) require(beats_left == 0, "new request before the burst completed");
            if (!disp_on) require(!avm_read, "avm_read asserted with the display off");

            // third frame runs with the display off, clear also hits the set cycle
            disp_on    = (vs_falls != 3);
            clr_vblank = synced && (c == 400 || (vs_falls == 3 && c == 0));

            // memory model, beats come only after the accepting edge
            avm_readdatavalid = 1'b0;
            if (beats_left > 0) begin
                gap = rand_bit() & rand_bit();
                if (!gap) begin
                    avm_readdatavalid = 1'b1;
                    avm_readdata      = {4'h0, word_idx[11:0]};
                    word_idx++;
                    beats_left--;
                end
            end
            avm_waitrequest = rand_bit();
            if (avm_read && !avm_waitrequest && beats_left == 0) begin
                expect_value("avm_address", avm_address,
                             disp_addr + 26'(2 * `DISP_BURST * burst_n));
                expect_value("avm_burstcount", avm_burstcount, `DISP_BURST);
                burst_n    = (burst_n + 1) % FRAME_BURST;
                word_idx   = avm_address >> 1;
                beats_left = `DISP_BURST;
            end
            read_q = avm_read;
            addr_q = avm_address;
        end
    end

    initial begin
        while (vs_falls < 5 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (vs_falls < 5) begin
            other_errs++;
            $display("ERROR: timed out after %0d clks waiting for the fifth VS fall", waited);
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* logic/disp_ip.sv */
`timescale 1ns/1ns
`include "disp_macros.svh"

module disp_ip (
    input  logic                          clk,
    input  logic                          rst,
    // avalon-mm read master
    input  logic                          avm_waitrequest,
    input  logic [15:0]                   avm_readdata,
    input  logic                          avm_readdatavalid,
    output logic [25:0]                   avm_address,
    output logic                          avm_read,
    output logic [$clog2(`DISP_BURST):0]  avm_burstcount,
    // vga
    output logic [3:0]                    vga_r,
    output logic [3:0]                    vga_g,
    output logic [3:0]                    vga_b,
    output logic                          vga_hs,
    output logic                          vga_vs,
    // gpio side
    input  logic [25:0]                   disp_addr,
    input  logic                          disp_on,
    input  logic                          clr_vblank,
    output logic                          vblank
);

    localparam int BC_W = $clog2(`DISP_BURST) + 1;

    disp_timing_if tim ();

    logic                   frame_start;
    logic                   fifo_rd;
    logic [`DISP_FIFO_AW:0] fifo_level;
    disp_pkg::pixel_u       fifo_wdata;
    disp_pkg::pixel_u       fifo_rdata;

    assign avm_burstcount  = BC_W'(`DISP_BURST);  // fixed length
    assign fifo_wdata.raw  = avm_readdata;

    syncgen i_syncgen (
        .clk         (clk),
        .rst         (rst),
        .clr_vblank  (clr_vblank),
        .tim         (tim.src),
        .frame_start (frame_start),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vblank      (vblank)
    );

    disp_ctrl i_disp_ctrl (
        .clk               (clk),
        .rst               (rst),
        .frame_start       (frame_start),
        .disp_on           (disp_on),
        .disp_addr         (disp_addr),
        .fifo_level        (fifo_level),
        .avm_waitrequest   (avm_waitrequest),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_address       (avm_address),
        .avm_read          (avm_read)
    );

    // vs low flushes leftovers before the next fetch
    disp_fifo i_disp_fifo (
        .clk   (clk),
        .rst   (rst),
        .clr   (~vga_vs),
        .wr    (avm_readdatavalid),
        .wdata (fifo_wdata),
        .rd    (fifo_rd),
        .rdata (fifo_rdata),
        .level (fifo_level)
    );

    disp_out i_disp_out (
        .clk       (clk),
        .rst       (rst),
        .disp_on   (disp_on),
        .tim       (tim.dst),
        .fifo_data (fifo_rdata),
        .fifo_rd   (fifo_rd),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

/* logic/disp_out.sv */
`timescale 1ns/1ns

module disp_out (
    input  logic             clk,
    input  logic             rst,
    input  logic             disp_on,
    disp_timing_if.dst       tim,
    input  disp_pkg::pixel_u fifo_data,
    output logic             fifo_rd,
    output logic [3:0]       vga_r,
    output logic [3:0]       vga_g,
    output logic [3:0]       vga_b
);

    logic frame_on;     // a fetch was started for this frame
    logic show;

    // follows the fetch side, which also starts only on frame_start
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_on <= 1'b0;
        end else if (!disp_on) begin
            frame_on <= 1'b0;
        end else if (tim.frame_start) begin
            frame_on <= 1'b1;
        end
    end

    assign show    = tim.active && disp_on && frame_on;
    assign fifo_rd = tim.pck && show;   // one word per pixel

    ////////////////////
    // rgb register, held across both clks of a pixel

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_r <= '0;
            vga_g <= '0;
            vga_b <= '0;
        end else if (tim.pck) begin
            vga_r <= show ? fifo_data.rgb.r : 4'h0;
            vga_g <= show ? fifo_data.rgb.g : 4'h0;
            vga_b <= show ? fifo_data.rgb.b : 4'h0;
        end
    end

endmodule

/* logic/disp_fifo.sv */
`timescale 1ns/1ns
`include "disp_macros.svh"

module disp_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clr,
    input  logic                   wr,
    input  disp_pkg::pixel_u       wdata,
    input  logic                   rd,
    output disp_pkg::pixel_u       rdata,
    output logic [`DISP_FIFO_AW:0] level
);

    disp_pkg::pixel_u mem [`DISP_FIFO_DEPTH];

    logic [`DISP_FIFO_AW-1:0] wptr;
    logic [`DISP_FIFO_AW-1:0] rptr;
    logic                     empty;
    logic                     full;
    logic                     do_wr;
    logic                     do_rd;

    assign empty = (level == '0);
    assign full  = (level == (`DISP_FIFO_AW + 1)'(`DISP_FIFO_DEPTH));
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;    // underflow leaves the pointer alone

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            wptr  <= '0;
            rptr  <= '0;
            level <= '0;
        end else begin
            if (do_wr) wptr <= wptr + 1'b1;
            if (do_rd) rptr <= rptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr] <= wdata;
        end
    end

    // show-ahead, zero word when empty
    assign rdata = empty ? '0 : mem[rptr];

endmodule

/* logic/disp_ctrl.sv */
`timescale 1ns/1ns
`include "disp_macros.svh"

module disp_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   frame_start,
    input  logic                   disp_on,
    input  logic [25:0]            disp_addr,
    input  logic [`DISP_FIFO_AW:0] fifo_level,
    input  logic                   avm_waitrequest,
    input  logic                   avm_readdatavalid,
    output logic [25:0]            avm_address,
    output logic                   avm_read
);

    localparam int FRAME_WORDS = `DISP_H_ACTIVE * `DISP_V_ACTIVE;
    localparam int LEFT_W      = $clog2(FRAME_WORDS + 1);
    localparam int BEAT_W      = $clog2(`DISP_BURST);
    localparam int LVL_W       = `DISP_FIFO_AW + 1;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1;
    localparam logic [1:0] S_RECV = 2'd2;

    logic [1:0]        state;
    logic [LEFT_W-1:0] words_left;   // words not yet requested
    logic [BEAT_W-1:0] beat_cnt;
    logic              start;
    logic              room;
    logic              accept;
    logic              last_beat;

    assign start     = (state == S_IDLE) && frame_start && disp_on;
    assign room      = (fifo_level <= LVL_W'(`DISP_FIFO_DEPTH - `DISP_BURST));
    assign accept    = avm_read && !avm_waitrequest;
    assign last_beat = avm_readdatavalid && (beat_cnt == BEAT_W'(`DISP_BURST - 1));

    ////////////////////
    // fsm

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            avm_read   <= 1'b0;
            words_left <= '0;
            beat_cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        words_left <= LEFT_W'(FRAME_WORDS);
                        state      <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (!avm_read) begin
                        avm_read <= room;   // wait until a whole burst fits
                    end else if (accept) begin
                        avm_read   <= 1'b0;
                        words_left <= words_left - LEFT_W'(`DISP_BURST);
                        beat_cnt   <= '0;
                        state      <= S_RECV;
                    end
                end
                S_RECV: begin
                    if (avm_readdatavalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        state <= (words_left == '0) ? S_IDLE : S_REQ;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // byte address, steps one burst of 16-bit words
    always_ff @(posedge clk) begin
        if (start) begin
            avm_address <= disp_addr;
        end else if (accept) begin
            avm_address <= avm_address + 26'(2 * `DISP_BURST);
        end
    end

endmodule

/* logic/syncgen.sv */
`timescale 1ns/1ns
`include "disp_macros.svh"

module syncgen (
    input  logic       clk,
    input  logic       rst,
    input  logic       clr_vblank,
    disp_timing_if.src tim,
    output logic       frame_start,
    output logic       vga_hs,
    output logic       vga_vs,
    output logic       vblank
);

    // fetch starts on the first line after VS, once the fifo clear is over
    localparam int FETCH_LINE = `DISP_V_SYNC_START + `DISP_V_SYNC_WIDTH;

    logic pck;
    logic h_end;
    logic v_end;
    logic hs_dec;
    logic vs_dec;
    logic vs_d;

    ////////////////////
    // pixel strobe and raster counters

    always_ff @(posedge clk) begin
        if (rst) begin
            pck <= 1'b0;
        end else begin
            pck <= ~pck;
        end
    end

    assign h_end = (tim.hcnt == 10'(`DISP_H_TOTAL - 1));
    assign v_end = (tim.vcnt == 10'(`DISP_V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            tim.hcnt <= '0;
            tim.vcnt <= '0;
        end else if (pck) begin
            tim.hcnt <= h_end ? '0 : tim.hcnt + 1'b1;
            if (h_end) begin
                tim.vcnt <= v_end ? '0 : tim.vcnt + 1'b1;
            end
        end
    end

    assign tim.pck         = pck;
    assign tim.active      = (tim.hcnt < 10'(`DISP_H_ACTIVE)) &&
                             (tim.vcnt < 10'(`DISP_V_ACTIVE));
    assign tim.frame_start = pck && (tim.hcnt == '0) && (tim.vcnt == 10'(FETCH_LINE));
    assign frame_start     = tim.frame_start;

    ////////////////////
    // sync pulses, updated on pck so they line up with rgb

    assign hs_dec = (tim.hcnt >= 10'(`DISP_H_SYNC_START)) &&
                    (tim.hcnt < 10'(`DISP_H_SYNC_START + `DISP_H_SYNC_WIDTH));
    assign vs_dec = (tim.vcnt >= 10'(`DISP_V_SYNC_START)) &&
                    (tim.vcnt < 10'(`DISP_V_SYNC_START + `DISP_V_SYNC_WIDTH));

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_hs <= 1'b1;
            vga_vs <= 1'b1;
        end else if (pck) begin
            vga_hs <= ~hs_dec;  // active low
            vga_vs <= ~vs_dec;
        end
    end

    ////////////////////
    // sticky vblank for the cpu

    always_ff @(posedge clk) begin
        if (rst) begin
            vs_d   <= 1'b1;
            vblank <= 1'b0;
        end else begin
            vs_d <= vga_vs;
            if (clr_vblank) begin
                vblank <= 1'b0;         // clear beats set
            end else if (vs_d && !vga_vs) begin
                vblank <= 1'b1;
            end
        end
    end

endmodule

/* logic/disp_timing_if.sv */
`timescale 1ns/1ns

interface disp_timing_if;
    logic       pck;            // pixel strobe, high every second clk
    logic [9:0] hcnt;
    logic [9:0] vcnt;
    logic       active;         // inside the visible window
    logic       frame_start;    // one pck wide

    modport src (
        output pck,
        output hcnt,
        output vcnt,
        output active,
        output frame_start
    );

    modport dst (
        input pck,
        input hcnt,
        input vcnt,
        input active,
        input frame_start
    );
endinterface

/* logic/disp_pkg.sv */
package disp_pkg;

    // color view of one memory word, top nibble unused
    typedef struct packed {
        logic [3:0] unused;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // fifo moves raw words, the output stage reads rgb
    typedef union packed {
        logic [15:0] raw;
        rgb_t        rgb;
    } pixel_u;

endpackage

/* logic/disp_macros.svh */
`ifndef DISP_MACROS_SVH
`define DISP_MACROS_SVH

// horizontal timing in pixels
`define DISP_H_ACTIVE       32
`define DISP_H_TOTAL        48
`define DISP_H_SYNC_START   36
`define DISP_H_SYNC_WIDTH   4

// vertical timing in lines
`define DISP_V_ACTIVE       8
`define DISP_V_TOTAL        12
`define DISP_V_SYNC_START   9
`define DISP_V_SYNC_WIDTH   2

// avalon burst length in 16-bit words
`define DISP_BURST          16

// pixel fifo, depth must be 2**aw
`define DISP_FIFO_DEPTH     64
`define DISP_FIFO_AW        6

`endif
